// File: include/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define DATA_W 32          // operand width

// cycles from start accepted to ready pulse
`define MUL_LATENCY 3

`define DIV_STEPS `DATA_W  // one quotient bit per step

`endif

// File: source/aluPkg.sv
`include "alu_config.svh"

package aluPkg;

    // grouped encoding, low bits pick the member of a group
    typedef enum logic [7:0] {
        NOP  = 8'h00,  // passes srcA through
        AND  = 8'h01, OR, NOR, XOR,
        ADD  = 8'h08, ADDU, SUB, SUBU,
        SLT  = 8'h10, SLTU,
        SLLV = 8'h18, SRLV, SRAV, SLL, SRL, SRA,
        LUI  = 8'h20,
        MULT = 8'h28, MULTU, DIV, DIVU,
        MTHI = 8'h30, MTLO, MFHI, MFLO,
        CLO  = 8'h38, CLZ,
        SEB  = 8'h40, SEH
    } aluOp_e;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE   // sign fix-up, ready pulse
    } divState_e;

    typedef enum logic [1:0] {
        BOTH,
        HI_ONLY,
        LO_ONLY
    } hiloSel_e;

    typedef struct packed {
        aluOp_e             op;
        logic [`DATA_W-1:0] srcA;
        logic [`DATA_W-1:0] srcB;
        logic [4:0]         sa;     // shift amount, SLL/SRL/SRA
    } aluReq_t;

    typedef struct packed {
        logic [2*`DATA_W-1:0] result;
        logic                 overflow;
    } aluResp_t;

    // product, or remainder in hi and quotient in lo
    typedef struct packed {
        logic [`DATA_W-1:0] hi;
        logic [`DATA_W-1:0] lo;
    } hiLo_t;

endpackage

// File: source/mulUnit.sv
`include "alu_config.svh"

module mulUnit (
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                flush_i,
    input  logic                start_i,
    input  logic                signed_i,
    input  logic [`DATA_W-1:0]  opA_i,
    input  logic [`DATA_W-1:0]  opB_i,
    output logic                ready_o,
    output aluPkg::hiLo_t       result_o
);
    localparam int W   = `DATA_W;
    localparam int LAT = `MUL_LATENCY;

    logic [LAT-1:0]  vld;
    logic            busy;
    logic            accept;
    logic [W-1:0]    magA;
    logic [W-1:0]    magB;
    logic            negIn;
    logic [W-1:0]    magAReg;
    logic [W-1:0]    magBReg;
    logic            negReg;
    logic [2*W-1:0]  prodPipe [0:LAT-3];
    logic            negPipe [0:LAT-3];
    aluPkg::hiLo_t   resReg;

    assign accept = start_i && !busy;
    assign magA   = (signed_i && opA_i[W-1]) ? -opA_i : opA_i;
    assign magB   = (signed_i && opB_i[W-1]) ? -opB_i : opB_i;
    assign negIn  = signed_i && (opA_i[W-1] ^ opB_i[W-1]);

    always_ff @(posedge clk) begin
        if (!rstN_i || flush_i) begin
            busy <= 1'b0;
            vld  <= '0;
        end else begin
            vld <= {vld[LAT-2:0], accept};
            if (accept) begin
                busy <= 1'b1;
            end else if (ready_o) begin
                busy <= 1'b0;  // free again after the pulse
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            magAReg <= magA;
            magBReg <= magB;
            negReg  <= negIn;
        end
        prodPipe[0] <= magAReg * magBReg;
        negPipe[0]  <= negReg;
        for (int k = 1; k <= LAT - 3; k++) begin
            prodPipe[k] <= prodPipe[k-1];
            negPipe[k]  <= negPipe[k-1];
        end
        resReg <= aluPkg::hiLo_t'(negPipe[LAT-3] ? -prodPipe[LAT-3] : prodPipe[LAT-3]);
    end

    assign ready_o  = vld[LAT-1];
    assign result_o = resReg;

endmodule

// File: source/divUnit.sv
`include "alu_config.svh"

module divUnit (
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                flush_i,
    input  logic                start_i,
    input  logic                signed_i,
    input  logic [`DATA_W-1:0]  opA_i,     // dividend
    input  logic [`DATA_W-1:0]  opB_i,     // divisor
    output logic                ready_o,
    output aluPkg::hiLo_t       result_o
);
    localparam int W  = `DATA_W;
    localparam int CW = $clog2(`DIV_STEPS);
    localparam logic [CW-1:0] LAST_STEP = CW'(`DIV_STEPS - 1);

    aluPkg::divState_e state;
    logic [CW-1:0]     stepCnt;
    logic              accept;
    logic [W-1:0]      magA;
    logic [W-1:0]      magB;
    logic [W-1:0]      quoReg;
    logic [W-1:0]      remReg;
    logic [W-1:0]      divisorReg;
    logic              negQuo;
    logic              negRem;
    logic [W:0]        partRem;
    logic [W:0]        trialRem;
    logic              fits;

    assign accept = (state == aluPkg::IDLE) && start_i;
    assign magA   = (signed_i && opA_i[W-1]) ? -opA_i : opA_i;
    assign magB   = (signed_i && opB_i[W-1]) ? -opB_i : opB_i;

    // shift next dividend bit into the partial remainder
    assign partRem  = {remReg, quoReg[W-1]};
    assign trialRem = partRem - {1'b0, divisorReg};
    assign fits     = partRem >= {1'b0, divisorReg};

    always_ff @(posedge clk) begin
        if (!rstN_i || flush_i) begin
            state   <= aluPkg::IDLE;
            stepCnt <= '0;
        end else begin
            case (state)
                aluPkg::IDLE: begin
                    if (start_i) begin
                        state   <= aluPkg::BUSY;
                        stepCnt <= '0;
                    end
                end
                aluPkg::BUSY: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == LAST_STEP) begin
                        state <= aluPkg::DONE;
                    end
                end
                default: begin
                    state <= aluPkg::IDLE;   // DONE lasts one cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            quoReg     <= magA;
            remReg     <= '0;
            divisorReg <= magB;
            negQuo     <= signed_i && (opA_i[W-1] ^ opB_i[W-1]);
            negRem     <= signed_i && opA_i[W-1];
        end else if (state == aluPkg::BUSY) begin
            quoReg <= {quoReg[W-2:0], fits};
            // restore by keeping the unsubtracted value
            remReg <= fits ? trialRem[W-1:0] : partRem[W-1:0];
        end
    end

    assign ready_o = (state == aluPkg::DONE);

    // truncate toward zero, remainder follows the dividend
    assign result_o.lo = negQuo ? -quoReg : quoReg;
    assign result_o.hi = negRem ? -remReg : remReg;

endmodule

// File: source/hiloReg.sv
`include "alu_config.svh"

module hiloReg (
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                we_i,
    input  aluPkg::hiloSel_e    sel_i,
    input  aluPkg::hiLo_t       wdata_i,
    input  logic                rdHi_i,
    output logic [`DATA_W-1:0]  rdata_o
);
    aluPkg::hiLo_t hiLo;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            hiLo <= '0;
        end else if (we_i) begin
            if (sel_i != aluPkg::LO_ONLY) begin
                hiLo.hi <= wdata_i.hi;
            end
            if (sel_i != aluPkg::HI_ONLY) begin
                hiLo.lo <= wdata_i.lo;
            end
        end
    end

    assign rdata_o = rdHi_i ? hiLo.hi : hiLo.lo;  // MFHI or MFLO

endmodule

// File: source/execAlu.sv
`include "alu_config.svh"

module execAlu (
    input  logic              clk,
    input  logic              rstN_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  logic              flushException_i,
    input  aluPkg::aluReq_t   req_i,
    output logic              aluStall_o,
    output aluPkg::aluResp_t  resp_o
);
    localparam int W    = `DATA_W;
    localparam int SHW  = $clog2(W);
    localparam int CNTW = $clog2(W + 1);

    logic [W-1:0]      srcA;
    logic [W-1:0]      srcB;
    logic [W-1:0]      sum;
    logic [W-1:0]      diff;
    logic [W-1:0]      lowRes;
    logic [2*W-1:0]    fullRes;
    logic              overflow;
    logic              mulStart;
    logic              mulSigned;
    logic              mulReady;
    logic              divStart;
    logic              divSigned;
    logic              divReady;
    aluPkg::hiLo_t     mulRes;
    aluPkg::hiLo_t     divRes;
    logic              hiloWr;
    aluPkg::hiloSel_e  hiloSel;
    logic              rdHi;
    logic [W-1:0]      hiloRd;

    // leading bits equal to b, counted from the msb
    function automatic logic [CNTW-1:0] leadCount(input logic [W-1:0] v, input logic b);
        logic [CNTW-1:0] n;
        logic            hit;
        n   = '0;
        hit = 1'b0;
        for (int i = W - 1; i >= 0; i--) begin
            if (v[i] != b) begin
                hit = 1'b1;
            end
            if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign srcA = req_i.srcA;
    assign srcB = req_i.srcB;
    assign sum  = srcA + srcB;
    assign diff = srcA - srcB;
    assign rdHi = (req_i.op == aluPkg::MFHI);

    always_comb begin
        lowRes     = '0;
        overflow   = 1'b0;
        mulStart   = 1'b0;
        mulSigned  = 1'b0;
        divStart   = 1'b0;
        divSigned  = 1'b0;
        aluStall_o = 1'b0;
        hiloWr     = 1'b0;
        hiloSel    = aluPkg::BOTH;
        case (req_i.op)
            aluPkg::NOP:   lowRes = srcA;
            aluPkg::AND:   lowRes = srcA & srcB;
            aluPkg::OR:    lowRes = srcA | srcB;
            aluPkg::NOR:   lowRes = ~(srcA | srcB);
            aluPkg::XOR:   lowRes = srcA ^ srcB;
            aluPkg::ADD: begin
                lowRes   = sum;
                overflow = (srcA[W-1] == srcB[W-1]) && (sum[W-1] != srcA[W-1]);
            end
            aluPkg::ADDU:  lowRes = sum;
            aluPkg::SUB: begin
                lowRes   = diff;
                overflow = (srcA[W-1] != srcB[W-1]) && (diff[W-1] != srcA[W-1]);
            end
            aluPkg::SUBU:  lowRes = diff;
            aluPkg::SLT:   lowRes = W'($signed(srcA) < $signed(srcB));
            aluPkg::SLTU:  lowRes = W'(srcA < srcB);
            aluPkg::SLLV:  lowRes = srcB << srcA[SHW-1:0];
            aluPkg::SRLV:  lowRes = srcB >> srcA[SHW-1:0];
            aluPkg::SRAV:  lowRes = $signed(srcB) >>> srcA[SHW-1:0];
            aluPkg::SLL:   lowRes = srcB << req_i.sa;
            aluPkg::SRL:   lowRes = srcB >> req_i.sa;
            aluPkg::SRA:   lowRes = $signed(srcB) >>> req_i.sa;
            aluPkg::LUI:   lowRes = {srcB[W/2-1:0], {(W/2){1'b0}}};
            aluPkg::MULT, aluPkg::MULTU: begin
                mulSigned  = (req_i.op == aluPkg::MULT);
                mulStart   = !mulReady;  // held until the ready pulse
                aluStall_o = !mulReady;
                hiloWr     = mulReady && !stall_i;
            end
            aluPkg::DIV, aluPkg::DIVU: begin
                divSigned  = (req_i.op == aluPkg::DIV);
                divStart   = !divReady;
                aluStall_o = !divReady;
                hiloWr     = divReady && !stall_i;
            end
            aluPkg::MTHI: begin
                hiloSel = aluPkg::HI_ONLY;
                hiloWr  = !stall_i;
            end
            aluPkg::MTLO: begin
                lowRes  = srcA;
                hiloSel = aluPkg::LO_ONLY;
                hiloWr  = !stall_i;
            end
            aluPkg::MFHI, aluPkg::MFLO: lowRes = hiloRd;
            aluPkg::CLO:   lowRes = W'(leadCount(srcA, 1'b1));
            aluPkg::CLZ:   lowRes = W'(leadCount(srcA, 1'b0));
            aluPkg::SEB:   lowRes = {{(W-8){srcB[7]}}, srcB[7:0]};
            aluPkg::SEH:   lowRes = {{(W-16){srcB[15]}}, srcB[15:0]};
            default:       lowRes = '0;
        endcase
    end

    // wide results, everything else sits in the low word
    always_comb begin
        case (req_i.op)
            aluPkg::MULT, aluPkg::MULTU: fullRes = mulRes;
            aluPkg::DIV, aluPkg::DIVU:   fullRes = divRes;
            aluPkg::MTHI:                fullRes = {srcA, {W{1'b0}}};
            default:                     fullRes = {{W{1'b0}}, lowRes};
        endcase
    end

    assign resp_o.result   = fullRes;
    assign resp_o.overflow = overflow;

    mulUnit mul_i (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .flush_i  (flush_i),
        .start_i  (mulStart),
        .signed_i (mulSigned),
        .opA_i    (srcA),
        .opB_i    (srcB),
        .ready_o  (mulReady),
        .result_o (mulRes)
    );

    divUnit div_i (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .flush_i  (flush_i),
        .start_i  (divStart),
        .signed_i (divSigned),
        .opA_i    (srcA),
        .opB_i    (srcB),
        .ready_o  (divReady),
        .result_o (divRes)
    );

    // write data is the result itself, hi in the top half
    hiloReg hilo_i (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .we_i     (hiloWr && !flushException_i),
        .sel_i    (hiloSel),
        .wdata_i  (aluPkg::hiLo_t'(fullRes)),
        .rdHi_i   (rdHi),
        .rdata_o  (hiloRd)
    );

endmodule

// File: tb/clockGen.sv
module clockGen (
    output logic clk_o,
    output logic rstN_o
);
    localparam int HALF_PERIOD = 50;

    initial begin
        clk_o  = 1'b0;
        rstN_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rstN_o <= 1'b1;  // released after four cycles
    end

    always #HALF_PERIOD clk_o = ~clk_o;

endmodule

// File: tb/execAluTb.sv
`include "alu_config.svh"

module execAluTb;

    localparam int RESET_CYCLES = 4;

    typedef struct packed {
        logic [7:0]       kind;
        aluPkg::aluReq_t  req;
        aluPkg::aluResp_t exp;
    } testCase_t;

    logic             clk;
    logic             rstN;
    logic             stall;
    logic             flush;
    logic             flushExc;
    aluPkg::aluReq_t  req;
    logic             aluStall;
    aluPkg::aluResp_t resp;
    testCase_t        cases[$];
    bit               loaded;
    int               caseIdx;

    clockGen clk_i (
        .clk_o  (clk),
        .rstN_o (rstN)
    );

    execAlu dut_i (
        .clk              (clk),
        .rstN_i           (rstN),
        .stall_i          (stall),
        .flush_i          (flush),
        .flushException_i (flushExc),
        .req_i            (req),
        .aluStall_o       (aluStall),
        .resp_o           (resp)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkResp(input aluPkg::aluResp_t exp, input aluPkg::aluResp_t act);
        if (act !== exp) begin
            abortRun($sformatf("FAIL resp_o case %0d expected %h actual %h",
                               caseIdx, exp, act));
        end
    endtask

    task automatic checkStall(input logic exp, input logic act);
        if (act !== exp) begin
            abortRun($sformatf("FAIL aluStall_o case %0d expected %h actual %h",
                               caseIdx, exp, act));
        end
    endtask

    task automatic loadCases();
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [7:0]       opNum;
        logic [31:0]      srcA;
        logic [31:0]      srcB;
        logic [4:0]       sa;
        logic [63:0]      res;
        logic             ovf;
        logic [8*160-1:0] rest;
        testCase_t        c;
        fd = $fopen("tb/alu_cases.txt", "r");
        if (fd == 0) begin
            abortRun("could not open the cases file tb/alu_cases.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "#") begin
                code = $fgets(rest, fd);  // column description
            end else if (kind != "S" && kind != "M" && kind != "E" && kind != "H") begin
                abortRun($sformatf("the cases file has an unknown case kind %c", kind));
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h", opNum, srcA, srcB, sa, res, ovf);
                if (code != 6) begin
                    abortRun("a line of the cases file has too few columns");
                end else begin
                    c.kind         = kind;
                    c.req.op       = aluPkg::aluOp_e'(opNum);
                    c.req.srcA     = srcA;
                    c.req.srcB     = srcB;
                    c.req.sa       = sa;
                    c.exp.result   = res;
                    c.exp.overflow = ovf;
                    cases.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    // E and H cases raise flushException_i or stall_i for that cycle only
    task automatic runCase(input testCase_t c);
        @(posedge clk);
        req      <= c.req;
        flushExc <= (c.kind == "E");
        stall    <= (c.kind == "H");
        @(negedge clk);
        if (c.kind == "M") begin
            checkStall(1'b1, aluStall);
            while (aluStall) begin
                @(negedge clk);  // unit still busy
            end
        end else begin
            checkStall(1'b0, aluStall);
        end
        checkResp(c.exp, resp);
    endtask

    // bound taken from the slowest case, a full division
    initial begin
        int limit;
        wait (loaded);
        limit = cases.size() * (`DIV_STEPS + 8) + RESET_CYCLES + 2;
        repeat (limit) @(posedge clk);
        abortRun("timeout, the DUT hung before all cases were done");
    end

    initial begin
        req      = '0;
        stall    = 1'b0;
        flush    = 1'b0;
        flushExc = 1'b0;
        caseIdx  = 0;
        loadCases();
        loaded = 1'b1;
        wait (rstN === 1'b1);
        for (caseIdx = 0; caseIdx < cases.size(); caseIdx++) begin
            runCase(cases[caseIdx]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
source/aluPkg.sv
source/mulUnit.sv
source/divUnit.sv
source/hiloReg.sv
source/execAlu.sv
tb/clockGen.sv
tb/execAluTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f vlog.f --top-module execAluTb -o simv &&
./obj_dir/simv || exit 1

// File: tb/alu_cases.txt
# kind op srcA srcB sa expected_result overflow, all hex
# kind S single-cycle, M multi-cycle, E with flushException_i, H with stall_i
S 01 f0f0ff00 0ff0f0f0 00 0000000000f0f000 0
S 02 f0f0ff00 0ff0f0f0 00 00000000fff0fff0 0
S 03 12345678 0000ffff 00 00000000edcb0000 0
S 04 aaaa5555 ffff0000 00 0000000055555555 0
S 00 deadbeef 12345678 00 00000000deadbeef 0
S 08 7fffffff 00000001 00 0000000080000000 1
S 08 fffffffe 00000005 00 0000000000000003 0
S 09 7fffffff 00000001 00 0000000080000000 0
S 0a 80000000 00000001 00 000000007fffffff 1
S 0a 7fffffff ffffffff 00 0000000080000000 1
S 0b 00000000 00000001 00 00000000ffffffff 0
S 10 ffffffff 00000001 00 0000000000000001 0
S 18 00000004 0000000f 00 00000000000000f0 0
S 19 00000024 80000000 00 0000000008000000 0
S 1a 00000008 80001234 00 00000000ff800012 0
S 1b 00000000 00000001 1f 0000000080000000 0
S 1c 00000000 f0000000 1c 000000000000000f 0
S 20 00000000 0000abcd 00 00000000abcd0000 0
S 38 ffffffff 00000000 00 0000000000000020 0
S 38 fff0ffff 00000000 00 000000000000000c 0
S 39 00000000 00000000 00 0000000000000020 0
S 39 ffffffff 00000000 00 0000000000000000 0
S 40 00000000 12345680 00 00000000ffffff80 0
S 41 00000000 00007fff 00 0000000000007fff 0
M 28 fffffffd 00000007 00 ffffffffffffffeb 0
S 32 00000000 00000000 00 00000000ffffffff 0
S 33 00000000 00000000 00 00000000ffffffeb 0
M 29 ffffffff ffffffff 00 fffffffe00000001 0
S 32 00000000 00000000 00 00000000fffffffe 0
M 2a fffffff9 00000002 00 fffffffffffffffd 0
S 33 00000000 00000000 00 00000000fffffffd 0
M 2a 00000007 fffffffe 00 00000001fffffffd 0
S 32 00000000 00000000 00 0000000000000001 0
M 2b 80000000 00000003 00 000000022aaaaaaa 0
S 30 13572468 00000000 00 1357246800000000 0
S 31 0badcafe 00000000 00 000000000badcafe 0
S 32 00000000 00000000 00 0000000013572468 0
E 31 11111111 00000000 00 0000000011111111 0
S 33 00000000 00000000 00 000000000badcafe 0
H 31 22222222 00000000 00 0000000022222222 0
S 33 00000000 00000000 00 000000000badcafe 0
